//--- hw/z80_bus_pkg.sv
`default_nettype none

package z80_bus_pkg;

   // ********************
   // Host bus widths
   // ********************
   localparam int z80_addr_w = 22;                 // Full host address incl. socket bits

   typedef logic [z80_addr_w-1:0] z80_addr_t;      // Host address
   typedef logic [7:0]            z80_byte_t;      // One data byte

   // ********************
   // Decode constants
   // ********************
   localparam logic [2:0] mem_window_code = 3'b010; // Bits 21..19, socket at 0x100000
   localparam logic [7:0] io_spkr_port    = 8'd242; // Speaker enable port
   localparam logic [7:0] io_blnk_port    = 8'd243; // DAC blank port

   // Direction pin of the 245 data converter
   localparam logic dir_to_fpga = 1'b0;             // B->A, host writes
   localparam logic dir_to_z80  = 1'b1;             // A->B, host reads

endpackage

`default_nettype wire

//--- hw/gpu_mem_pkg.sv
`default_nettype none

package gpu_mem_pkg;

   // ********************
   // GPU RAM geometry
   // ********************
   localparam int gpu_addr_w    = 19;              // 512 KB window offset
   localparam int mem_size_bits = 15;              // 32 KB populated

   typedef logic [gpu_addr_w-1:0] gpu_addr_t;      // GPU RAM address

   // ********************
   // Bank identification
   // ********************
   // Block sits in the top 16 bytes of the window, 0x17FFF0..0x17FFFF
   localparam logic [17:0] bank_id_block = 18'h17FFF; // Host address bits 21..4

   localparam logic [7:0] bank_id_table [16] = '{
      8'd9,  8'd3,  8'd71, 8'd80,                  // Offsets 0..3
      8'd85, 8'd32, 8'd69, 8'd80,                  // Offsets 4..7
      8'd52, 8'd67, 8'd69, 8'd54,                  // Offsets 8..11
      8'd0,  8'd255, 8'd255, 8'd255                // Offsets 12..15, tail padding
   };

endpackage

`default_nettype wire

//--- hw/z80_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface z80_req_if
   import z80_bus_pkg::*;
();

   logic      mem_wr;       // Window write, in range, strobe held
   logic      mem_rd;       // Window read, strobe held
   logic      in_range;     // Address below RAM limit
   logic      bank_hit;     // Address in bank ID block
   z80_addr_t addr;         // Registered host address
   z80_byte_t wdata;        // Registered host write data
   logic      spkr_start;   // First cycle of speaker port write
   logic      blnk_start;   // First cycle of blank port write

   // Decoder side
   modport source (
      output mem_wr, mem_rd, in_range, bank_hit,
      output addr, wdata, spkr_start, blnk_start
   );

   // Users of the decoded request
   modport sink (
      input mem_wr, mem_rd, in_range, bank_hit,
      input addr, wdata, spkr_start, blnk_start
   );

endinterface

`default_nettype wire

//--- hw/z80_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bus_decode
   import z80_bus_pkg::*;
   import gpu_mem_pkg::*;
(
   input  wire            GPU_CLK,
   input  wire            rst_n,
   input  wire            z80_mreq_n,   // Memory request, active low
   input  wire            z80_m1_n,     // Opcode fetch / INTA, active low
   input  wire            z80_iorq_n,   // IO request, active low
   input  wire            z80_wr_n,     // Write strobe, active low
   input  wire            z80_rd_n,     // Read strobe, active low
   input  wire z80_addr_t z80_addr,
   input  wire z80_byte_t z80_wdata,
   z80_req_if.source      req
);

   logic mem_cycle;                     // Plain memory cycle, not M1
   logic in_window;
   logic addr_in_range;
   logic addr_bank_hit;
   logic spkr_hit;
   logic blnk_hit;
   logic spkr_prev;                     // Port match one cycle back
   logic blnk_prev;

   assign mem_cycle     = ~z80_mreq_n & z80_m1_n;
   assign in_window     = (z80_addr[z80_addr_w-1 -: 3] == mem_window_code);
   assign addr_in_range = (z80_addr[gpu_addr_w-1:mem_size_bits] == '0); // Below 2^15
   assign addr_bank_hit = (z80_addr[z80_addr_w-1:4] == bank_id_block);

   // IO port matches, write cycles only
   assign spkr_hit = ~z80_iorq_n & ~z80_wr_n & (z80_addr[7:0] == io_spkr_port);
   assign blnk_hit = ~z80_iorq_n & ~z80_wr_n & (z80_addr[7:0] == io_blnk_port);

   // ********************
   // Registered cycle type
   // ********************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         req.mem_wr     <= 1'b0;
         req.mem_rd     <= 1'b0;
         req.in_range   <= 1'b0;
         req.bank_hit   <= 1'b0;
         req.spkr_start <= 1'b0;
         req.blnk_start <= 1'b0;
         spkr_prev      <= 1'b0;
         blnk_prev      <= 1'b0;
      end else begin
         req.mem_wr     <= mem_cycle & in_window & addr_in_range & ~z80_wr_n; // RAM writes only
         req.mem_rd     <= mem_cycle & in_window & ~z80_rd_n;  // Whole window readable
         req.in_range   <= addr_in_range;
         req.bank_hit   <= addr_bank_hit;
         req.spkr_start <= spkr_hit & ~spkr_prev;              // Rising edge of match
         req.blnk_start <= blnk_hit & ~blnk_prev;
         spkr_prev      <= spkr_hit;
         blnk_prev      <= blnk_hit;
      end
   end

   // Address and data follow the pins every cycle
   always_ff @(posedge GPU_CLK) begin
      req.addr  <= z80_addr;
      req.wdata <= z80_wdata;
   end

endmodule

`default_nettype wire

//--- hw/gpu_ram_access.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_ram_access
   import z80_bus_pkg::*;
   import gpu_mem_pkg::*;
(
   input  wire            GPU_CLK,
   input  wire            rst_n,
   z80_req_if.sink        req,
   input  wire            gpu_rd_rdy,   // One cycle, RAM byte valid
   input  wire z80_byte_t gpu_rdata,
   output logic           gpu_wr_ena,   // One-cycle write pulse
   output logic           gpu_rd_req,   // One-cycle read request
   output gpu_addr_t      gpu_addr,
   output z80_byte_t      gpu_wdata,
   output z80_byte_t      reply_byte    // Byte for the host data path
);

   logic      wr_prev;
   logic      rd_prev;
   logic      wr_start;                 // First cycle of a held write
   logic      rd_start;
   logic      rd_in_range;              // Range tests captured at read start
   logic      rd_bank_hit;
   z80_byte_t reply_sel;
   z80_byte_t reply_q;                  // Last reply, held for the bus

   assign wr_start = req.mem_wr & ~wr_prev;
   assign rd_start = req.mem_rd & ~rd_prev;

   // Reply source: RAM, bank ID table or open bus
   always_comb begin
      if (rd_in_range) begin
         reply_sel = gpu_rdata;
      end else if (rd_bank_hit) begin
         reply_sel = bank_id_table[gpu_addr[3:0]]; // Offset within block
      end else begin
         reply_sel = 8'hFF;
      end
   end

   assign reply_byte = gpu_rd_rdy ? reply_sel : reply_q; // Bypass on the ready cycle

   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         wr_prev     <= 1'b0;
         rd_prev     <= 1'b0;
         gpu_wr_ena  <= 1'b0;
         gpu_rd_req  <= 1'b0;
         rd_in_range <= 1'b0;
         rd_bank_hit <= 1'b0;
         reply_q     <= '0;
      end else begin
         wr_prev    <= req.mem_wr;
         rd_prev    <= req.mem_rd;
         gpu_wr_ena <= wr_start;        // Single pulse per strobe
         gpu_rd_req <= rd_start;
         if (rd_start) begin
            rd_in_range <= req.in_range;
            rd_bank_hit <= req.bank_hit;
         end
         if (gpu_rd_rdy) reply_q <= reply_sel;
      end
   end

   // Address and data latched once per access
   always_ff @(posedge GPU_CLK) begin
      if (wr_start || rd_start) gpu_addr <= req.addr[gpu_addr_w-1:0];
      if (wr_start) gpu_wdata <= req.wdata;
   end

endmodule

`default_nettype wire

//--- hw/z80_io_ports.sv
`timescale 1ns/1ps
`default_nettype none

module z80_io_ports (
   input  wire     GPU_CLK,
   input  wire     rst_n,
   z80_req_if.sink req,
   output logic    video_en,            // DAC blank control, high shows video
   output logic    spkr_en              // One-cycle speaker trigger
);

   logic data_nz;                       // Written byte is non-zero

   assign data_nz = |req.wdata;

   // ********************
   // Blank port
   // ********************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         video_en <= 1'b1;              // Video on out of reset
      end else if (req.blnk_start) begin
         video_en <= data_nz;           // Zero blanks the DAC
      end
   end

   // ********************
   // Speaker port
   // ********************
   // The start pulse lasts one cycle, so the output drops again by itself
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         spkr_en <= 1'b0;
      end else begin
         spkr_en <= req.spkr_start & data_nz; // Zero data gives no pulse
      end
   end

endmodule

`default_nettype wire

//--- hw/z80_data_driver.sv
`timescale 1ns/1ps
`default_nettype none

module z80_data_driver
   import z80_bus_pkg::*;
(
   input  wire            GPU_CLK,
   input  wire            rst_n,
   z80_req_if.sink        req,
   input  wire z80_byte_t reply_byte,
   output logic           z80_245_dir,   // Converter direction
   output logic           z80_245_oe,    // Converter enable, active low
   output logic           z80_rdata_ena, // FPGA drives the data pins
   output z80_byte_t      z80_rdata
);

   // ********************
   // Data bus control
   // ********************
   always_ff @(posedge GPU_CLK or negedge rst_n) begin
      if (!rst_n) begin
         z80_245_dir   <= dir_to_fpga;
         z80_245_oe    <= 1'b1;          // Converter off
         z80_rdata_ena <= 1'b0;
         z80_rdata     <= '0;
      end else if (req.mem_rd) begin
         z80_245_dir   <= dir_to_z80;    // Toward host
         z80_245_oe    <= 1'b0;
         z80_rdata_ena <= 1'b1;
         z80_rdata     <= reply_byte;    // Tracks the reply as it arrives
      end else if (req.mem_wr) begin
         z80_245_dir   <= dir_to_fpga;   // Toward FPGA
         z80_245_oe    <= 1'b0;
         z80_rdata_ena <= 1'b0;
         z80_rdata     <= '0;
      end else begin
         // Idle bus, pins released
         z80_245_dir   <= dir_to_fpga;
         z80_245_oe    <= 1'b1;
         z80_rdata_ena <= 1'b0;
         z80_rdata     <= '0;            // Zero byte stands in for high-Z
      end
   end

endmodule

`default_nettype wire

//--- hw/z80_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bridge
   import z80_bus_pkg::*;
   import gpu_mem_pkg::*;
(
   input  wire            GPU_CLK,
   input  wire            rst_n,
   // Host bus
   input  wire            z80_mreq_n,
   input  wire            z80_m1_n,
   input  wire            z80_iorq_n,
   input  wire            z80_wr_n,
   input  wire            z80_rd_n,
   input  wire z80_addr_t z80_addr,
   input  wire z80_byte_t z80_wdata,
   // GPU RAM
   input  wire            gpu_rd_rdy,
   input  wire z80_byte_t gpu_rdata,
   output logic           gpu_wr_ena,
   output logic           gpu_rd_req,
   output gpu_addr_t      gpu_addr,
   output z80_byte_t      gpu_wdata,
   // IO port outputs
   output logic           video_en,
   output logic           spkr_en,
   // Data converter and read data
   output logic           z80_245_dir,
   output logic           z80_245_oe,
   output logic           z80_rdata_ena,
   output z80_byte_t      z80_rdata
);

   z80_byte_t reply_byte;               // RAM side to data driver

   z80_req_if req_bus ();               // Decoded request, one cycle after pins

   z80_bus_decode u_decode (
      .GPU_CLK    (GPU_CLK),
      .rst_n      (rst_n),
      .z80_mreq_n (z80_mreq_n),
      .z80_m1_n   (z80_m1_n),
      .z80_iorq_n (z80_iorq_n),
      .z80_wr_n   (z80_wr_n),
      .z80_rd_n   (z80_rd_n),
      .z80_addr   (z80_addr),
      .z80_wdata  (z80_wdata),
      .req        (req_bus.source)
   );

   gpu_ram_access u_ram (
      .GPU_CLK    (GPU_CLK),
      .rst_n      (rst_n),
      .req        (req_bus.sink),
      .gpu_rd_rdy (gpu_rd_rdy),
      .gpu_rdata  (gpu_rdata),
      .gpu_wr_ena (gpu_wr_ena),
      .gpu_rd_req (gpu_rd_req),
      .gpu_addr   (gpu_addr),
      .gpu_wdata  (gpu_wdata),
      .reply_byte (reply_byte)
   );

   z80_io_ports u_io (
      .GPU_CLK  (GPU_CLK),
      .rst_n    (rst_n),
      .req      (req_bus.sink),
      .video_en (video_en),
      .spkr_en  (spkr_en)
   );

   z80_data_driver u_drv (
      .GPU_CLK       (GPU_CLK),
      .rst_n         (rst_n),
      .req           (req_bus.sink),
      .reply_byte    (reply_byte),
      .z80_245_dir   (z80_245_dir),
      .z80_245_oe    (z80_245_oe),
      .z80_rdata_ena (z80_rdata_ena),
      .z80_rdata     (z80_rdata)
   );

endmodule

`default_nettype wire

//--- test/z80_bridge_chk.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bridge_chk
   import z80_bus_pkg::*;
(
   input wire            GPU_CLK,
   input wire            rst_n,
   input wire            gpu_wr_ena,
   input wire            gpu_rd_req,
   input wire            spkr_en,
   input wire            z80_245_dir,
   input wire            z80_245_oe,
   input wire            z80_rdata_ena,
   input wire z80_byte_t z80_rdata
);

   int unsigned fail_cnt = 0;          // Failed assertions so far

   // ********************
   // Single-cycle pulses
   // ********************
   wr_pulse_a : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      gpu_wr_ena |=> !gpu_wr_ena)
      else begin
         fail_cnt++;
         $error("gpu_wr_ena high for more than one cycle");
      end

   rd_pulse_a : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      gpu_rd_req |=> !gpu_rd_req)
      else begin
         fail_cnt++;
         $error("gpu_rd_req high for more than one cycle");
      end

   spkr_pulse_a : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      spkr_en |=> !spkr_en)
      else begin
         fail_cnt++;
         $error("spkr_en high for more than one cycle");
      end

   // ********************
   // Data bus control
   // ********************
   rd_dir_a : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      z80_rdata_ena |-> (z80_245_dir == dir_to_z80) && !z80_245_oe)
      else begin
         fail_cnt++;
         $error("read data enabled while converter is off or points to the FPGA");
      end

   idle_data_a : assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      !z80_rdata_ena |-> (z80_rdata == 8'h00))
      else begin
         fail_cnt++;
         $error("non-zero read data while the data pins are released");
      end

endmodule

bind z80_bridge z80_bridge_chk u_chk (
   .GPU_CLK       (GPU_CLK),
   .rst_n         (rst_n),
   .gpu_wr_ena    (gpu_wr_ena),
   .gpu_rd_req    (gpu_rd_req),
   .spkr_en       (spkr_en),
   .z80_245_dir   (z80_245_dir),
   .z80_245_oe    (z80_245_oe),
   .z80_rdata_ena (z80_rdata_ena),
   .z80_rdata     (z80_rdata)
);

`default_nettype wire

//--- test/z80_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bridge_tb
   import z80_bus_pkg::*;
   import gpu_mem_pkg::*;
();

   localparam int unsigned max_cycles = 2000;  // 5 tests x 40 transactions x ~10 cycles
   localparam int          n_trans    = 40;    // Transactions per test

   logic      GPU_CLK = 1'b0;
   logic      rst_n;
   logic      z80_mreq_n;
   logic      z80_m1_n;
   logic      z80_iorq_n;
   logic      z80_wr_n;
   logic      z80_rd_n;
   z80_addr_t z80_addr;
   z80_byte_t z80_wdata;
   logic      gpu_rd_rdy = 1'b0;               // Driven by the RAM model
   z80_byte_t gpu_rdata  = '0;
   logic      gpu_wr_ena;
   logic      gpu_rd_req;
   gpu_addr_t gpu_addr;
   z80_byte_t gpu_wdata;
   logic      video_en;
   logic      spkr_en;
   logic      z80_245_dir;
   logic      z80_245_oe;
   logic      z80_rdata_ena;
   z80_byte_t z80_rdata;

   logic [31:0]              lfsr = 32'ha2f52b01; // Fixed seed
   z80_byte_t                ram [0:(1 << mem_size_bits)-1]; // GPU RAM model
   logic                     ram_ready = 1'b0;
   logic [2:0]               rd_delay;         // Reply delay for the next read
   logic [2:0]               rd_cnt = '0;
   logic [mem_size_bits-1:0] rd_addr = '0;
   int unsigned              cycles = 0;
   int unsigned              wr_pulses = 0;
   int unsigned              rd_pulses = 0;
   int unsigned              spkr_pulses = 0;
   int unsigned              errors = 0;
   int unsigned              checks = 0;
   int unsigned              tests = 0;

   z80_bridge DUT (.*);

   always #50 GPU_CLK = ~GPU_CLK;              // 100 ns period

   // ********************
   // GPU RAM model
   // ********************
   always @(negedge GPU_CLK) begin
      if (!ram_ready) begin
         for (int i = 0; i < (1 << mem_size_bits); i++) begin
            ram[i] = 8'(i) ^ 8'(i >> 7) ^ 8'h5A; // Pattern over the whole address
         end
         ram_ready = 1'b1;
      end
      if (gpu_wr_ena) ram[gpu_addr[mem_size_bits-1:0]] = gpu_wdata;
      gpu_rd_rdy <= 1'b0;
      if (gpu_rd_req) begin
         rd_cnt  <= rd_delay;                  // 1 to 4 cycles
         rd_addr <= gpu_addr[mem_size_bits-1:0];
      end else if (rd_cnt == 3'd1) begin
         gpu_rd_rdy <= 1'b1;
         gpu_rdata  <= ram[rd_addr];
         rd_cnt     <= '0;
      end else if (rd_cnt != '0) begin
         rd_cnt <= rd_cnt - 3'd1;
      end
   end

   // Pulse counters and watchdog
   always @(posedge GPU_CLK) begin
      cycles++;
      if (gpu_wr_ena) wr_pulses++;
      if (gpu_rd_req) rd_pulses++;
      if (spkr_en) spkr_pulses++;
      if (cycles >= max_cycles) begin
         $display("Timeout: no result after %0d cycles", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // Galois LFSR, one step per bit
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Random address of one class
   task automatic pick_addr(input logic [1:0] cls, output z80_addr_t a);
      logic [31:0] v;
      take_bits(21, v);
      case (cls)
         2'd0:    a = {mem_window_code, 4'h0, v[14:0]};            // RAM
         2'd1:    a = {mem_window_code, v[18:15] | 4'h1, v[14:0]}; // Above RAM
         2'd2:    a = {bank_id_block, v[3:0]};                      // Bank ID block
         default: a = {mem_window_code ^ {v[20:19], 1'b1}, v[18:0]}; // Outside window
      endcase
   endtask

   task automatic mem_write(input z80_addr_t a, input z80_byte_t d, input int exp_n);
      int unsigned n0;
      n0         = wr_pulses;
      z80_addr   = a;
      z80_wdata  = d;
      z80_mreq_n = 1'b0;
      z80_wr_n   = 1'b0;
      repeat (4) @(negedge GPU_CLK);           // Strobe held
      expect_eq("z80_245_oe", 32'(z80_245_oe), (exp_n == 1) ? 32'd0 : 32'd1);
      expect_eq("z80_245_dir", 32'(z80_245_dir), 32'(dir_to_fpga));
      z80_mreq_n = 1'b1;
      z80_wr_n   = 1'b1;
      repeat (3) @(negedge GPU_CLK);
      expect_eq("write pulses", wr_pulses - n0, 32'(exp_n));
      if (exp_n == 1) begin
         expect_eq("gpu_addr", 32'(gpu_addr), 32'(a[gpu_addr_w-1:0]));
         expect_eq("gpu_wdata", 32'(gpu_wdata), 32'(d));
      end
   endtask

   task automatic mem_read(input z80_addr_t a, input z80_byte_t exp_byte);
      logic [31:0] r;
      int unsigned n0;
      take_bits(2, r);
      rd_delay   = {1'b0, r[1:0]} + 3'd1;
      n0         = rd_pulses;
      z80_addr   = a;
      z80_mreq_n = 1'b0;
      z80_rd_n   = 1'b0;
      @(posedge GPU_CLK);
      while (!gpu_rd_rdy) @(posedge GPU_CLK); // Watchdog bounds the wait
      @(negedge GPU_CLK);
      expect_eq("z80_rdata_ena", 32'(z80_rdata_ena), 32'd1);
      expect_eq("z80_245_dir", 32'(z80_245_dir), 32'(dir_to_z80));
      expect_eq("z80_rdata", 32'(z80_rdata), 32'(exp_byte));
      z80_mreq_n = 1'b1;
      z80_rd_n   = 1'b1;
      repeat (3) @(negedge GPU_CLK);
      expect_eq("read requests", rd_pulses - n0, 32'd1);
   endtask

   task automatic port_write(input logic [7:0] port, input z80_byte_t d);
      logic [31:0] r;
      take_bits(14, r);                        // Upper address bits are don't care
      z80_addr   = {r[13:0], port};
      z80_wdata  = d;
      z80_iorq_n = 1'b0;
      z80_wr_n   = 1'b0;
      repeat (3) @(negedge GPU_CLK);
      z80_iorq_n = 1'b1;
      z80_wr_n   = 1'b1;
      repeat (3) @(negedge GPU_CLK);
   endtask

   task automatic end_test(input string name, input int unsigned err0);
      tests++;
      if (errors == err0) begin
         $display("Test %0d %s: ok", tests, name);
      end else begin
         $display("Test %0d %s: %0d errors", tests, name, errors - err0);
      end
   endtask

   // ********************
   // Test sequence
   // ********************
   initial begin
      logic [31:0] r;
      logic [31:0] d;
      z80_addr_t   a;
      int unsigned err0;
      int unsigned n0;
      rst_n      = 1'b0;
      z80_mreq_n = 1'b1;
      z80_m1_n   = 1'b1;                       // No opcode fetches
      z80_iorq_n = 1'b1;
      z80_wr_n   = 1'b1;
      z80_rd_n   = 1'b1;
      z80_addr   = '0;
      z80_wdata  = '0;
      rd_delay   = 3'd1;
      repeat (8) @(negedge GPU_CLK);
      rst_n = 1'b1;
      repeat (2) @(negedge GPU_CLK);

      err0 = errors;                           // Idle bus keeps reset values
      expect_eq("gpu_wr_ena", 32'(gpu_wr_ena), 32'd0);
      expect_eq("gpu_rd_req", 32'(gpu_rd_req), 32'd0);
      expect_eq("spkr_en", 32'(spkr_en), 32'd0);
      expect_eq("z80_rdata_ena", 32'(z80_rdata_ena), 32'd0);
      expect_eq("z80_245_oe", 32'(z80_245_oe), 32'd1);
      expect_eq("z80_245_dir", 32'(z80_245_dir), 32'(dir_to_fpga));
      expect_eq("z80_rdata", 32'(z80_rdata), 32'd0);
      expect_eq("video_en", 32'(video_en), 32'd1);
      end_test("reset values", err0);

      err0 = errors;
      for (int i = 0; i < n_trans; i++) begin
         take_bits(10, r);                     // Class and data
         pick_addr(r[9:8], a);
         mem_write(a, r[7:0], (r[9:8] == 2'd0) ? 1 : 0); // Only the RAM class lands
      end
      end_test("memory writes", err0);

      err0 = errors;
      for (int i = 0; i < n_trans; i++) begin
         pick_addr(2'd0, a);
         mem_read(a, ram[a[mem_size_bits-1:0]]);
      end
      end_test("RAM reads", err0);

      err0 = errors;
      for (int i = 0; i < n_trans; i++) begin
         take_bits(1, r);
         pick_addr({1'b0, r[0]} + 2'd1, a);    // Above RAM or bank ID block
         if (a[z80_addr_w-1:4] == bank_id_block) begin
            mem_read(a, bank_id_table[a[3:0]]);
         end else begin
            mem_read(a, 8'hFF);
         end
      end
      end_test("bank ID reads", err0);

      err0 = errors;
      for (int i = 0; i < n_trans; i++) begin
         take_bits(10, r);
         d = r[9] ? 32'd0 : 32'(r[7:0]);       // Zero data about half the time
         if (r[8]) begin
            port_write(io_blnk_port, d[7:0]);
            expect_eq("video_en", 32'(video_en), 32'(d[7:0] != 8'h00));
         end else begin
            n0 = spkr_pulses;
            port_write(io_spkr_port, d[7:0]);
            expect_eq("speaker pulses", spkr_pulses - n0, 32'(d[7:0] != 8'h00));
         end
      end
      end_test("IO ports", err0);

      $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
               tests, checks, errors, DUT.u_chk.fail_cnt);
      if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
hw/z80_bus_pkg.sv
hw/gpu_mem_pkg.sv
hw/z80_req_if.sv
hw/z80_bus_decode.sv
hw/gpu_ram_access.sv
hw/z80_io_ports.sv
hw/z80_data_driver.sv
hw/z80_bridge.sv
test/z80_bridge_chk.sv
test/z80_bridge_tb.sv

//--- Makefile
# Verilator build for the Z80 bridge testbench
VERILATOR ?= verilator
TOP       ?= z80_bridge_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
